// File: usb_sniffer.f
design/usb_sniffer_pkg.sv
design/fe_capture.sv
design/pattern_match.sv
design/capture_fifo.sv
design/usb_sniffer_top.sv
tb/usb_sniffer_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = usb_sniffer_tb
FILELIST  = usb_sniffer.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/usb_sniffer_tb.sv
// Sniffer testbench with clock, reset, LFSR stimulus, entry model, FIFO reader and watchdog
`default_nettype none

module usb_sniffer_tb;

    localparam int PATTERN_BYTES   = 2;
    localparam int FIFO_DEPTH      = 32;
    localparam int TW              = usb_sniffer_pkg::TIME_WIDTH;
    localparam int N_SHORT         = 24;
    localparam int N_LONG          = 40;
    localparam int N_PRE           = 10;
    localparam int N_POST          = 8;
    localparam int N_LEN           = 30;
    localparam int N_FULL          = 40;
    localparam int NUM_EVENTS      = N_SHORT + N_LONG + N_PRE + 2 + N_POST + N_LEN + N_FULL;
    localparam int WATCHDOG_CYCLES = 20 * NUM_EVENTS + 2000;
    localparam int READ_STALL      = 0;
    localparam int READ_CHECK      = 1;
    localparam int READ_COUNT      = 2;

    logic                         fe_clk = 1'b0;
    logic                         reset_i;
    logic [7:0]                   fe_data;
    logic                         fe_rxvalid;
    usb_sniffer_pkg::fe_status_t  fe_status;
    logic                         arm;
    logic                         timestamps_disable;
    logic                         immediate_trigger;
    logic [15:0]                  capture_len;
    logic [PATTERN_BYTES*8-1:0]   pattern;
    logic [PATTERN_BYTES*8-1:0]   pattern_mask;
    logic                         rd_en = 1'b0;
    usb_sniffer_pkg::fifo_entry_t rd_entry;
    logic                         empty;
    logic                         full;
    logic                         capturing;

    // Model and bookkeeping
    usb_sniffer_pkg::fifo_entry_t exp_q [$];
    int                           cycle_count = 0;
    int                           last_event_cycle = 0;
    bit                           gap_running = 1'b0;
    bit                           expect_idle = 1'b0;
    logic [31:0]                  lfsr_state;
    int                           reader_mode = READ_STALL;
    int                           popped = 0;
    int                           checks = 0;
    int                           value_errors = 0;
    int                           other_errors = 0;

    usb_sniffer_top #(
        .FIFO_DEPTH_LOG2 (5),
        .PATTERN_BYTES   (PATTERN_BYTES)
    ) dut_i (
        .fe_clk             (fe_clk),
        .reset_i            (reset_i),
        .fe_data            (fe_data),
        .fe_rxvalid         (fe_rxvalid),
        .fe_status          (fe_status),
        .arm                (arm),
        .timestamps_disable (timestamps_disable),
        .immediate_trigger  (immediate_trigger),
        .capture_len        (capture_len),
        .pattern            (pattern),
        .pattern_mask       (pattern_mask),
        .rd_en              (rd_en),
        .rd_entry           (rd_entry),
        .empty              (empty),
        .full               (full),
        .capturing          (capturing)
    );

    always #5 fe_clk = ~fe_clk;

    always @(posedge fe_clk) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////
    // Random numbers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    //////////////////////////////
    // Reference model

    task automatic push_entry(input usb_sniffer_pkg::fe_cmd_e cmd, input logic [7:0] data,
                              input usb_sniffer_pkg::fe_status_t status,
                              input logic [TW-1:0] stamp);
        usb_sniffer_pkg::fifo_entry_t e;
        e.cmd       = cmd;
        e.timestamp = stamp;
        e.data      = data;
        e.status    = status;
        exp_q.push_back(e);
    endtask

    // Idle cycles since the previous captured event give the gap
    task automatic note_event(input usb_sniffer_pkg::fe_cmd_e cmd, input logic [7:0] data,
                              input usb_sniffer_pkg::fe_status_t status);
        int gap;
        gap = cycle_count - last_event_cycle - 1;
        if (!gap_running) begin
            gap = 0;
        end
        if (!timestamps_disable && gap >= usb_sniffer_pkg::SHORT_GAP) begin
            push_entry(usb_sniffer_pkg::CMD_TIME, 8'h00, '0, TW'(gap));
        end
        push_entry(cmd, data, status, TW'(gap));
        gap_running      = 1'b1;
        last_event_cycle = cycle_count;
    endtask

    //////////////////////////////
    // Checking

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] gotv);
        value_errors++;
        $display("Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, expv, gotv);
    endtask

    task automatic check_entry(input usb_sniffer_pkg::fifo_entry_t got,
                               input usb_sniffer_pkg::fifo_entry_t exp);
        checks++;
        assert (got.cmd == exp.cmd)
            else report_mismatch("rd_entry.cmd", 32'(exp.cmd), 32'(got.cmd));
        if (got.cmd == exp.cmd) begin
            case (exp.cmd)
                usb_sniffer_pkg::CMD_DATA: begin
                    assert (got.data == exp.data)
                        else report_mismatch("rd_entry.data", 32'(exp.data), 32'(got.data));
                end
                usb_sniffer_pkg::CMD_STAT: begin
                    assert (got.status == exp.status)
                        else report_mismatch("rd_entry.status", 32'(exp.status),
                                             32'(got.status));
                end
                default: begin
                    assert (got.timestamp == exp.timestamp)
                        else report_mismatch("rd_entry.timestamp", 32'(exp.timestamp),
                                             32'(got.timestamp));
                end
            endcase
        end
    endtask

    no_capture_after_disarm: assert property (@(posedge fe_clk) disable iff (reset_i)
                                              !arm |=> !capturing)
        else begin
            other_errors++;
            $display("Capturing stayed high after arm fell at time %0t", $time);
        end

    no_capture_before_trigger: assert property (@(posedge fe_clk) disable iff (reset_i)
                                                expect_idle |-> !capturing)
        else begin
            other_errors++;
            $display("Capturing rose before the pattern at time %0t", $time);
        end

    // FIFO reader that pops whenever an entry is waiting
    always begin
        @(posedge fe_clk);
        #1;
        if (reset_i || empty || reader_mode == READ_STALL) begin
            rd_en = 1'b0;
        end else begin
            rd_en  = 1'b1;
            popped = popped + 1;
            if (reader_mode == READ_CHECK) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Unexpected entry with cmd %0d popped at time %0t",
                             rd_entry.cmd, $time);
                end else begin
                    check_entry(rd_entry, exp_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus helpers

    task automatic next_cycle();
        @(posedge fe_clk);
        #1;
        fe_rxvalid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_byte(input logic [7:0] value, input bit keep);
        next_cycle();
        fe_data    = value;
        fe_rxvalid = 1'b1;
        if (keep) begin
            note_event(usb_sniffer_pkg::CMD_DATA, value, fe_status);
        end
    endtask

    task automatic toggle_status(input int idx, input bit keep);
        usb_sniffer_pkg::fe_status_t next_status;
        next_cycle();
        next_status = fe_status ^ 5'(1 << idx);
        fe_status   = next_status;
        if (keep) begin
            note_event(usb_sniffer_pkg::CMD_STAT, 8'h00, next_status);
        end
    endtask

    task automatic arm_capture(input logic immediate, input logic ts_off, input logic [15:0] len);
        next_cycle();
        immediate_trigger  = immediate;
        timestamps_disable = ts_off;
        capture_len        = len;
        arm                = 1'b1;
        gap_running        = 1'b0;
        idle(4);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        idle(8);
        assert (empty)
            else begin
                other_errors++;
                $display("FIFO still holds entries at time %0t after the expected ones", $time);
            end
    endtask

    task automatic disarm();
        wait_drained();
        next_cycle();
        arm         = 1'b0;
        gap_running = 1'b0;
        idle(4);
    endtask

    task automatic wait_capturing();
        bit found;
        found = 1'b0;
        for (int i = 0; i < 8 && !found; i++) begin
            next_cycle();
            found = capturing;
        end
        assert (found)
            else begin
                other_errors++;
                $display("Capturing did not rise after the pattern at time %0t", $time);
            end
    endtask

    //////////////////////////////
    // Watchdog

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge fe_clk);
        $display("Watchdog timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Result: %0d entries checked, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // Main sequence

    initial begin
        logic [7:0] b;
        reset_i            = 1'b1;
        fe_data            = 8'h00;
        fe_rxvalid         = 1'b0;
        fe_status          = '0;
        arm                = 1'b0;
        timestamps_disable = 1'b1;
        immediate_trigger  = 1'b1;
        capture_len        = 16'hFFFF;
        pattern            = 16'hA53C;
        pattern_mask       = 16'hFFF0;
        lfsr_state         = 32'd97014;
        repeat (16) @(posedge fe_clk);
        #1;
        reset_i = 1'b0;
        assert (empty && !full && !capturing)
            else begin
                other_errors++;
                $display("Outputs not at their reset values after reset");
            end
        reader_mode = READ_CHECK;

        // Immediate trigger with short gaps and timestamps off
        arm_capture(1'b1, 1'b1, 16'hFFFF);
        for (int i = 0; i < N_SHORT; i++) begin
            idle(int'(lfsr_bits(3)));
            send_byte(lfsr_bits(8), 1'b1);
        end
        disarm();

        // Long gaps and status changes with timestamps on
        arm_capture(1'b1, 1'b0, 16'hFFFF);
        for (int i = 0; i < N_LONG; i++) begin
            if (lfsr_bits(1) == 8'd1) begin
                idle(usb_sniffer_pkg::SHORT_GAP + int'(lfsr_bits(4)));
            end else begin
                idle(int'(lfsr_bits(3)));
            end
            if (lfsr_bits(2) == 8'd0) begin
                toggle_status(int'(lfsr_bits(3)) % 5, 1'b1);
            end else begin
                send_byte(lfsr_bits(8), 1'b1);
            end
        end
        disarm();

        // Pattern trigger where the newest byte differs only in masked bits
        arm_capture(1'b0, 1'b1, 16'hFFFF);
        expect_idle = 1'b1;
        for (int i = 0; i < N_PRE; i++) begin
            idle(int'(lfsr_bits(2)));
            b = lfsr_bits(8);
            if (b == pattern[15:8]) begin
                b = ~b;
            end
            send_byte(b, 1'b0);
        end
        idle(2);
        send_byte(pattern[15:8], 1'b0);
        expect_idle = 1'b0;
        send_byte(pattern[7:0] ^ 8'h06, 1'b0);
        wait_capturing();
        idle(2);
        for (int i = 0; i < N_POST; i++) begin
            idle(int'(lfsr_bits(2)));
            send_byte(lfsr_bits(8), 1'b1);
        end
        disarm();

        // Capture length of 10 entries
        reader_mode = READ_COUNT;
        popped      = 0;
        arm_capture(1'b1, 1'b1, 16'd10);
        for (int i = 0; i < N_LEN; i++) begin
            idle(1 + int'(lfsr_bits(1)));
            send_byte(lfsr_bits(8), 1'b0);
        end
        idle(10);
        while (!empty) begin
            next_cycle();
        end
        idle(4);
        assert (popped >= 10 && popped <= 12)
            else begin
                other_errors++;
                $display("Capture length 10 gave %0d entries", popped);
            end
        assert (!capturing)
            else begin
                other_errors++;
                $display("Capturing still high after the capture length was reached");
            end
        disarm();

        // FIFO full with the reader stalled so only the oldest entries are kept
        reader_mode = READ_STALL;
        arm_capture(1'b1, 1'b1, 16'hFFFF);
        for (int i = 0; i < N_FULL; i++) begin
            idle(1 + int'(lfsr_bits(1)));
            send_byte(lfsr_bits(8), i < FIFO_DEPTH);
        end
        idle(4);
        assert (full)
            else begin
                other_errors++;
                $display("FIFO did not report full after %0d bytes", N_FULL);
            end
        popped      = 0;
        reader_mode = READ_CHECK;
        disarm();
        assert (popped <= FIFO_DEPTH)
            else begin
                other_errors++;
                $display("%0d entries popped from a FIFO of depth %0d", popped, FIFO_DEPTH);
            end

        idle(10);
        $display("Result: %0d entries checked, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/usb_sniffer_top.sv
// Sniffer capture path top level joining capture block, pattern matcher and entry FIFO
`default_nettype none

module usb_sniffer_top #(
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter int PATTERN_BYTES   = 2
) (
    input  logic                         fe_clk,
    input  logic                         reset_i,
    // Front end
    input  logic [7:0]                   fe_data,
    input  logic                         fe_rxvalid,
    input  usb_sniffer_pkg::fe_status_t  fe_status,
    // Control levels
    input  logic                         arm,
    input  logic                         timestamps_disable,
    input  logic                         immediate_trigger,
    input  logic [15:0]                  capture_len,
    input  logic [PATTERN_BYTES*8-1:0]   pattern,
    input  logic [PATTERN_BYTES*8-1:0]   pattern_mask,
    // FIFO reader
    input  logic                         rd_en,
    output usb_sniffer_pkg::fifo_entry_t rd_entry,
    output logic                         empty,
    output logic                         full,
    output logic                         capturing
);

    usb_sniffer_pkg::fifo_entry_t entry;
    logic                         entry_wr;
    logic [7:0]                   pm_data;
    logic                         pm_wr;
    logic                         capture_enable;

    //////////////////////////////
    // Capture, trigger and storage

    fe_capture fe_capture_i (
        .fe_clk             (fe_clk),
        .reset_i            (reset_i),
        .fe_data            (fe_data),
        .fe_rxvalid         (fe_rxvalid),
        .fe_status          (fe_status),
        .timestamps_disable (timestamps_disable),
        .arm                (arm),
        .capture_len        (capture_len),
        .capture_enable     (capture_enable),
        .full               (full),
        .entry              (entry),
        .entry_wr           (entry_wr),
        .pm_data            (pm_data),
        .pm_wr              (pm_wr),
        .capturing          (capturing)
    );

    pattern_match #(
        .PATTERN_BYTES (PATTERN_BYTES)
    ) pattern_match_i (
        .fe_clk            (fe_clk),
        .reset_i           (reset_i),
        .arm               (arm),
        .immediate_trigger (immediate_trigger),
        .pattern           (pattern),
        .pattern_mask      (pattern_mask),
        .pm_data           (pm_data),
        .pm_wr             (pm_wr),
        .capture_enable    (capture_enable)
    );

    capture_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) capture_fifo_i (
        .fe_clk   (fe_clk),
        .reset_i  (reset_i),
        .wr_entry (entry),
        .wr_en    (entry_wr),
        .rd_en    (rd_en),
        .rd_entry (rd_entry),
        .empty    (empty),
        .full     (full)
    );

endmodule

`default_nettype wire

// File: design/capture_fifo.sv
// Synchronous first-word fall-through FIFO of capture entries with full and empty flags
`default_nettype none

module capture_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 5
) (
    input  logic                         fe_clk,
    input  logic                         reset_i,
    input  usb_sniffer_pkg::fifo_entry_t wr_entry,
    input  logic                         wr_en,
    input  logic                         rd_en,
    output usb_sniffer_pkg::fifo_entry_t rd_entry,
    output logic                         empty,
    output logic                         full
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
    localparam int AW    = FIFO_DEPTH_LOG2;

    usb_sniffer_pkg::fifo_entry_t mem [0:DEPTH-1];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_write;
    logic        do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge fe_clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_entry;
        end
    end

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Head entry always visible
    assign rd_entry = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// File: design/pattern_match.sv
// Arm-triggered masked byte pattern matcher with immediate trigger mode
`default_nettype none

module pattern_match #(
    parameter int PATTERN_BYTES = 2
) (
    input  logic                       fe_clk,
    input  logic                       reset_i,
    input  logic                       arm,
    input  logic                       immediate_trigger,
    // Newest byte sits in the low byte lane
    input  logic [PATTERN_BYTES*8-1:0] pattern,
    input  logic [PATTERN_BYTES*8-1:0] pattern_mask,
    input  logic [7:0]                 pm_data,
    input  logic                       pm_wr,
    output logic                       capture_enable
);

    localparam int PW = PATTERN_BYTES * 8;

    typedef enum logic [1:0] {
        PM_IDLE = 2'b00,
        PM_WAIT = 2'b01,
        PM_TRIG = 2'b10
    } pm_state_e;

    pm_state_e                state;
    logic                     arm_r;
    logic                     arm_rise;
    logic [PW-1:0]            history;
    logic [PW-1:0]            history_next;
    logic [PATTERN_BYTES-1:0] filled;
    logic [PATTERN_BYTES-1:0] filled_next;
    logic                     match;

    assign arm_rise     = arm && !arm_r;
    assign history_next = (history << 8) | PW'(pm_data);
    assign filled_next  = (filled << 1) | PATTERN_BYTES'(1);

    // Only a full window of bytes since arming may match
    assign match = (&filled_next) && (((history_next ^ pattern) & pattern_mask) == '0);

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            arm_r  <= 1'b0;
            state  <= PM_IDLE;
            filled <= '0;
        end else begin
            arm_r <= arm;
            if (!arm) begin
                state <= PM_IDLE;
            end else begin
                case (state)
                    PM_IDLE: begin
                        if (arm_rise) begin
                            state <= immediate_trigger ? PM_TRIG : PM_WAIT;
                        end
                    end
                    PM_WAIT: begin
                        if (pm_wr && match) begin
                            state <= PM_TRIG;
                        end
                    end
                    default: begin
                        // Hold until arm falls
                        state <= PM_TRIG;
                    end
                endcase
            end
            if (arm_rise) begin
                filled <= '0;
            end else if (pm_wr) begin
                filled <= filled_next;
            end
        end
    end

    always_ff @(posedge fe_clk) begin
        if (arm_rise) begin
            history <= '0;
        end else if (pm_wr) begin
            history <= history_next;
        end
    end

    assign capture_enable = (state == PM_TRIG);

endmodule

`default_nettype wire

// File: design/fe_capture.sv
// Input delay stages, capture FSM, gap counter, capture length limit and matcher byte tap
`default_nettype none

module fe_capture (
    input  logic                         fe_clk,
    input  logic                         reset_i,
    // Front end
    input  logic [7:0]                   fe_data,
    input  logic                         fe_rxvalid,
    input  usb_sniffer_pkg::fe_status_t  fe_status,
    // Control levels
    input  logic                         timestamps_disable,
    input  logic                         arm,
    input  logic [15:0]                  capture_len,
    input  logic                         capture_enable,
    input  logic                         full,
    // FIFO write side
    output usb_sniffer_pkg::fifo_entry_t entry,
    output logic                         entry_wr,
    // Pattern matcher tap
    output logic [7:0]                   pm_data,
    output logic                         pm_wr,
    output logic                         capturing
);

    localparam int TW = usb_sniffer_pkg::TIME_WIDTH;
    localparam logic [TW-1:0] CTR_MAX       = '1;
    localparam logic [TW-1:0] CTR_WRAP      = CTR_MAX - 1'b1;
    localparam logic [TW-1:0] GAP_LIMIT     = TW'(usb_sniffer_pkg::SHORT_GAP);
    localparam logic [TW-1:0] GAP_LIMIT_PRE = TW'(usb_sniffer_pkg::SHORT_GAP - 1);

    // Input delay line
    logic                        rxvalid_q1;
    logic                        rxvalid_q2;
    logic [7:0]                  data_q1;
    logic [7:0]                  data_q2;
    logic [7:0]                  data_q3;
    usb_sniffer_pkg::fe_status_t status_q1;
    usb_sniffer_pkg::fe_status_t status_q2;
    usb_sniffer_pkg::fe_status_t status_q3;
    logic                        usb_event;
    logic                        usb_event_q;

    // FSM and gap counter
    usb_sniffer_pkg::fe_state_e  state;
    usb_sniffer_pkg::fe_state_e  next_state;
    usb_sniffer_pkg::fe_state_e  state_r;
    usb_sniffer_pkg::fe_state_e  state_r2;
    logic [TW-1:0]               gap_ctr;
    logic [TW-1:0]               gap;
    logic [TW-1:0]               gap_r;
    logic                        ctr_running;
    logic                        ctr_wrap;
    logic                        short_gap;
    logic                        short_gap_pre;

    // Write side and length limit
    usb_sniffer_pkg::fe_cmd_e    cmd_q;
    logic [15:0]                 capture_count;
    logic                        arm_r;
    logic                        capture_allowed;

    //////////////////////////////
    // Input delay line

    // A received byte or any change of line status
    assign usb_event = fe_rxvalid || (fe_status != status_q1);

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            rxvalid_q1  <= 1'b0;
            rxvalid_q2  <= 1'b0;
            status_q1   <= '0;
            usb_event_q <= 1'b0;
        end else begin
            rxvalid_q1  <= fe_rxvalid;
            rxvalid_q2  <= rxvalid_q1;
            status_q1   <= fe_status;
            usb_event_q <= usb_event;
        end
    end

    // Three stages so the entry lines up with the registered write strobe
    always_ff @(posedge fe_clk) begin
        if (fe_rxvalid) begin
            data_q1 <= fe_data;
        end
        data_q2   <= data_q1;
        data_q3   <= data_q2;
        status_q2 <= status_q1;
        status_q3 <= status_q2;
    end

    //////////////////////////////
    // Capture FSM

    assign short_gap     = timestamps_disable || (gap_ctr < GAP_LIMIT);
    assign short_gap_pre = timestamps_disable || (gap_ctr < GAP_LIMIT_PRE);

    // Idle counter about to saturate, flush it as a TIME entry
    assign ctr_wrap = ctr_running && (gap_ctr == CTR_WRAP) && !usb_event && !usb_event_q
                      && !timestamps_disable && capture_allowed;

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            state <= usb_sniffer_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = usb_sniffer_pkg::S_IDLE;
        case (state)
            usb_sniffer_pkg::S_IDLE: begin
                if (usb_event_q && short_gap && capture_allowed) begin
                    next_state = usb_sniffer_pkg::S_DATA;
                end else if (usb_event && !short_gap_pre && capture_allowed) begin
                    // Long gap seen one cycle early so the TIME entry goes out first
                    next_state = usb_sniffer_pkg::S_TIME;
                end else if (ctr_wrap) begin
                    next_state = usb_sniffer_pkg::S_TIME;
                end
            end
            usb_sniffer_pkg::S_DATA: begin
                // Back-to-back events stay here
                if (usb_event_q) begin
                    next_state = usb_sniffer_pkg::S_DATA;
                end
            end
            usb_sniffer_pkg::S_TIME: begin
                if (usb_event_q && capture_allowed) begin
                    next_state = usb_sniffer_pkg::S_DATA;
                end
            end
            default: begin
                next_state = usb_sniffer_pkg::S_IDLE;
            end
        endcase
    end

    //////////////////////////////
    // Gap counter

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            gap_ctr     <= '0;
            gap         <= '0;
            gap_r       <= '0;
            ctr_running <= 1'b0;
            state_r     <= usb_sniffer_pkg::S_IDLE;
            state_r2    <= usb_sniffer_pkg::S_IDLE;
        end else begin
            state_r  <= state;
            state_r2 <= state_r;
            gap_r    <= gap;

            // Starts on the first event once capture is enabled
            if (capture_enable && usb_event_q) begin
                ctr_running <= 1'b1;
            end else if (!capture_enable) begin
                ctr_running <= 1'b0;
            end

            if (!ctr_running) begin
                gap_ctr <= '0;
                gap     <= '0;
            end else if (usb_event_q) begin
                gap     <= gap_ctr;
                gap_ctr <= '0;
            end else if (ctr_wrap) begin
                gap     <= CTR_MAX;
                gap_ctr <= '0;
            end else if (gap_ctr != CTR_MAX) begin
                gap_ctr <= gap_ctr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Entry write

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            cmd_q    <= usb_sniffer_pkg::CMD_DATA;
            entry_wr <= 1'b0;
        end else begin
            case (state)
                usb_sniffer_pkg::S_DATA: begin
                    cmd_q    <= rxvalid_q2 ? usb_sniffer_pkg::CMD_DATA
                                           : usb_sniffer_pkg::CMD_STAT;
                    entry_wr <= 1'b1;
                end
                usb_sniffer_pkg::S_TIME: begin
                    cmd_q    <= usb_sniffer_pkg::CMD_TIME;
                    entry_wr <= 1'b1;
                end
                default: begin
                    entry_wr <= 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        entry.cmd    = cmd_q;
        entry.data   = data_q3;
        entry.status = status_q3;
        if (state_r == usb_sniffer_pkg::S_TIME) begin
            entry.timestamp = gap;
        end else if (state_r2 == usb_sniffer_pkg::S_TIME) begin
            // Gap already reported by the TIME entry just before
            entry.timestamp = '0;
        end else begin
            entry.timestamp = gap_r;
        end
    end

    // Byte tap, one cycle behind fe_rxvalid
    assign pm_data = data_q1;

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            pm_wr <= 1'b0;
        end else begin
            pm_wr <= fe_rxvalid;
        end
    end

    //////////////////////////////
    // Capture length limit

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            capture_count <= '0;
            arm_r         <= 1'b0;
        end else begin
            arm_r <= arm;
            if (arm && !arm_r) begin
                capture_count <= '0;
            end else if (entry_wr) begin
                capture_count <= capture_count + 16'd1;
            end
        end
    end

    // Lags by a couple of cycles, so one or two extra entries may slip in
    assign capture_allowed = capture_enable && (capture_count < capture_len) && !full;
    assign capturing       = capture_allowed;

endmodule

`default_nettype wire

// File: design/usb_sniffer_pkg.sv
// Entry command and capture state enums, line status and FIFO entry structs, timing constants
`default_nettype none

package usb_sniffer_pkg;

    // Width of the gap counter and of the entry time field
    localparam int TIME_WIDTH = 16;

    // Gaps below this many cycles need no TIME entry
    localparam int SHORT_GAP = 8;

    // Kind of entry written to the FIFO
    typedef enum logic [1:0] {
        CMD_DATA = 2'b00,
        CMD_STAT = 2'b01,
        CMD_TIME = 2'b10
    } fe_cmd_e;

    // Capture FSM states
    typedef enum logic [1:0] {
        S_IDLE = 2'b00,
        S_DATA = 2'b01,
        S_TIME = 2'b10
    } fe_state_e;

    // Line status flags from the ULPI front end
    typedef struct packed {
        logic rxactive;
        logic rxerror;
        logic sessvld;
        logic sessend;
        logic vbusvld;
    } fe_status_t;

    // One FIFO entry, 31 bits
    typedef struct packed {
        fe_cmd_e               cmd;
        logic [TIME_WIDTH-1:0] timestamp;
        logic [7:0]            data;
        fe_status_t            status;
    } fifo_entry_t;

endpackage

`default_nettype wire
